//--- rtl/burst_fifo_pkg.sv
package burst_fifo_pkg;

   // storage depth, deliberately not a power of two
   localparam int fifo_slots_c = 6;
   // most words a producer may offer in one strobe
   localparam int max_push_c = 2;

   // slot index, wide enough for 0..5
   localparam int ptr_width_c = 3;
   // occupancy count, holds 0..6
   localparam int cnt_width_c = 3;
   // push count field, holds 0..2
   localparam int push_width_c = 2;

   // one payload word
   typedef logic [15:0] word_t;
   typedef logic [ptr_width_c-1:0] ptr_t;
   typedef logic [cnt_width_c-1:0] cnt_t;

   // producer request
   // word0 goes in first, word1 only counts when count is 2
   typedef struct packed {
      logic [push_width_c-1:0] count;
      word_t                   word0;
      word_t                   word1;
   } push_t;

   // status back to producer and consumer
   typedef struct packed {
      logic empty;
      cnt_t level;
      // one-cycle pulse, whole push was discarded
      logic push_drop;
      // one-cycle pulse, pop seen while empty
      logic pop_err;
   } status_t;

endpackage

//--- rtl/circ_ptr.sv
`timescale 1ns/1ps

// circular slot pointer
// advances by 0..max_push_c per cycle and wraps modulo fifo_slots_c
module circ_ptr
   import burst_fifo_pkg::*;
(
   input  logic                              clk,
   input  logic                              reset_i,
   input  logic [$clog2(max_push_c+1)-1:0]   add_i,
   output ptr_t                              ptr_o
);

   // registered pointer
   ptr_t ptr_r;
   // next pointer value
   ptr_t ptr_n;
   // plain sum, valid when no wrap happens
   ptr_t ptr_nowrap;
   // sum minus slot count, one extra bit so the sign is visible
   logic [ptr_width_c:0] ptr_wrap;

   // both candidates are formed side by side
   // so the add does not sit in front of a compare
   always_comb
   begin
      ptr_nowrap = ptr_t'(ptr_r + ptr_t'(add_i));
      ptr_wrap   = ({1'b0, ptr_r} + (ptr_width_c+1)'(add_i))
                   - (ptr_width_c+1)'(fifo_slots_c);
   end

   // msb clear means ptr + add reached the slot count
   // so the wrapped value is the one to take
   always_comb
   begin
      if (!ptr_wrap[ptr_width_c])
      begin
         ptr_n = ptr_wrap[ptr_width_c-1:0];
      end
      else
      begin
         ptr_n = ptr_nowrap;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         ptr_r <= '0;
      end
      else
      begin
         ptr_r <= ptr_n;
      end
   end

   assign ptr_o = ptr_r;

endmodule

//--- rtl/burst_fifo_ctrl.sv
`timescale 1ns/1ps

// admission control and occupancy tracking
// decides how far each pointer moves this cycle
module burst_fifo_ctrl
   import burst_fifo_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset_i,
   input  logic                    push_stb_i,
   input  logic [push_width_c-1:0] push_cnt_i,
   input  logic                    pop_stb_i,
   output logic [push_width_c-1:0] wadd_o,
   output logic                    radd_o,
   output status_t                 status_o
);

   // occupancy, 0..fifo_slots_c
   cnt_t level_r;
   cnt_t level_n;
   // free slots including the one a same-cycle pop releases
   cnt_t room;
   // request decode
   logic push_req;
   logic push_ok;
   logic pop_ok;
   // registered error pulses
   logic drop_r;
   logic pop_err_r;

   // pop only when something is stored
   assign pop_ok = pop_stb_i && (level_r != '0);

   // room never exceeds fifo_slots_c
   // a pop is only possible when at least one slot is taken
   assign room = cnt_t'(fifo_slots_c) - level_r + cnt_t'(pop_ok);

   // a zero count strobe does nothing at all
   assign push_req = push_stb_i && (push_cnt_i != '0);

   // all or nothing, oversized counts never fit
   assign push_ok = push_req
                    && (int'(push_cnt_i) <= max_push_c)
                    && (cnt_t'(push_cnt_i) <= room);

   // accepted amounts, wadd_o also serves as the store write count
   assign wadd_o = push_ok ? push_cnt_i : '0;
   assign radd_o = pop_ok;

   // level after this cycle's accepted traffic
   assign level_n = level_r + cnt_t'(wadd_o) - cnt_t'(radd_o);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         level_r <= '0;
      end
      else
      begin
         level_r <= level_n;
      end
   end

   // flags are rebuilt every cycle, so each lasts one cycle per offending strobe
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         drop_r    <= 1'b0;
         pop_err_r <= 1'b0;
      end
      else
      begin
         drop_r    <= push_req && !push_ok;
         pop_err_r <= pop_stb_i && !pop_ok;
      end
   end

   // empty follows the registered level
   always_comb
   begin
      status_o.empty     = (level_r == '0);
      status_o.level     = level_r;
      status_o.push_drop = drop_r;
      status_o.pop_err   = pop_err_r;
   end

endmodule

//--- rtl/burst_fifo_store.sv
`timescale 1ns/1ps

// six-slot word store
// paired write at the write pointer, head read at the read pointer
module burst_fifo_store
   import burst_fifo_pkg::*;
(
   input  logic                    clk,
   input  ptr_t                    wptr_i,
   input  logic [push_width_c-1:0] wcnt_i,
   input  push_t                   wdata_i,
   input  ptr_t                    rptr_i,
   output word_t                   head_o
);

   // payload registers, contents only matter once written
   word_t mem_r [fifo_slots_c];
   // slot after the write pointer, wraps 5 -> 0
   ptr_t  wptr_nx;
   // per-word write enables
   logic  we0;
   logic  we1;

   always_comb
   begin
      if (wptr_i == ptr_t'(fifo_slots_c - 1))
      begin
         wptr_nx = '0;
      end
      else
      begin
         wptr_nx = ptr_t'(wptr_i + ptr_t'(1));
      end
   end

   // count is already the accepted amount from control
   assign we0 = (wcnt_i == 2'd1) || (wcnt_i == 2'd2);
   assign we1 = (wcnt_i == 2'd2);

   // word0 first, word1 into the following slot
   // the two slots always differ since the store has more than one slot
   always_ff @(posedge clk)
   begin
      if (we0)
      begin
         mem_r[wptr_i] <= wdata_i.word0;
      end
      if (we1)
      begin
         mem_r[wptr_nx] <= wdata_i.word1;
      end
   end

   // head is combinational off the registered read pointer
   // rptr_i stays below fifo_slots_c by construction
   assign head_o = mem_r[rptr_i];

endmodule

//--- rtl/burst_fifo.sv
`timescale 1ns/1ps

// burst FIFO top
// pushes of 0..2 words per strobe, pops of one word, no back-pressure
module burst_fifo
   import burst_fifo_pkg::*;
(
   input  logic    clk,
   input  logic    reset_i,
   input  logic    push_stb_i,
   input  push_t   push_i,
   input  logic    pop_stb_i,
   output word_t   head_o,
   output status_t status_o
);

   // accepted write advance, also the store write count
   logic [push_width_c-1:0]           wadd;
   // accepted pop, one bit from control
   logic                              radd;
   // read advance widened to the pointer add port
   logic [$clog2(max_push_c+1)-1:0]   radd_ext;
   ptr_t                              wptr;
   ptr_t                              rptr;

   assign radd_ext = {1'b0, radd};

   burst_fifo_ctrl i_ctrl (
      .clk        (clk),
      .reset_i    (reset_i),
      .push_stb_i (push_stb_i),
      .push_cnt_i (push_i.count),
      .pop_stb_i  (pop_stb_i),
      .wadd_o     (wadd),
      .radd_o     (radd),
      .status_o   (status_o)
   );

   // write side moves by 0..2
   circ_ptr i_wptr (
      .clk     (clk),
      .reset_i (reset_i),
      .add_i   (wadd),
      .ptr_o   (wptr)
   );

   // read side moves by 0 or 1
   circ_ptr i_rptr (
      .clk     (clk),
      .reset_i (reset_i),
      .add_i   (radd_ext),
      .ptr_o   (rptr)
   );

   burst_fifo_store i_store (
      .clk     (clk),
      .wptr_i  (wptr),
      .wcnt_i  (wadd),
      .wdata_i (push_i),
      .rptr_i  (rptr),
      .head_o  (head_o)
   );

endmodule

//--- dv/burst_fifo_props.sv
`timescale 1ns/1ps

// concurrent checks on the admission control
module burst_fifo_props
   import burst_fifo_pkg::*;
(
   input logic                    clk,
   input logic                    reset_i,
   input logic                    push_stb_i,
   input logic [push_width_c-1:0] push_cnt_i,
   input logic                    pop_stb_i,
   input logic [push_width_c-1:0] wadd_o,
   input status_t                 status_o
);

   // failed assertions, read by the testbench verdict
   int unsigned fail_cnt = 0;

   level_max_a: assert property (@(posedge clk) disable iff (reset_i)
      status_o.level <= cnt_t'(fifo_slots_c))
      else begin fail_cnt++; $error("level above slot count"); end

   // a drop pulse repeats only for a fresh rejected push
   drop_pulse_a: assert property (@(posedge clk) disable iff (reset_i)
      (status_o.push_drop && !(push_stb_i && (push_cnt_i != '0) && (wadd_o == '0)))
      |=> !status_o.push_drop)
      else begin fail_cnt++; $error("push_drop held longer than one cycle"); end

   // same for pop errors, a fresh pop while empty may retrigger
   pop_err_pulse_a: assert property (@(posedge clk) disable iff (reset_i)
      (status_o.pop_err && !(pop_stb_i && status_o.empty)) |=> !status_o.pop_err)
      else begin fail_cnt++; $error("pop_err held longer than one cycle"); end

   no_strobe_no_write_a: assert property (@(posedge clk) disable iff (reset_i)
      !push_stb_i |-> (wadd_o == '0))
      else begin fail_cnt++; $error("write advance without push strobe"); end

endmodule

bind burst_fifo_ctrl burst_fifo_props i_props (.*);

//--- dv/burst_fifo_tb.sv
`timescale 1ns/1ps

// burst FIFO testbench
// queue model predicts every cycle, a separate process compares
module burst_fifo_tb
   import burst_fifo_pkg::*;
();

   localparam int clk_period_c = 40;
   localparam int drive_dly_c = 2;
   localparam int reset_cycles_c = 10;
   // generous upper bound for all directed tests together
   localparam int directed_cycles_c = 200;
   localparam int rand_cycles_c = 400;
   localparam int limit_cycles_c = (reset_cycles_c + directed_cycles_c + rand_cycles_c) * 2;
   localparam logic [31:0] seed_c = 32'hac81_c054;

   // one predicted step of the admission rules
   typedef struct packed {
      logic [push_width_c-1:0] acc;
      logic                    pop_ok;
      logic                    drop;
      logic                    perr;
   } step_t;

   logic    clk;
   logic    reset_i;
   logic    push_stb;
   push_t   push;
   logic    pop_stb;
   word_t   head;
   status_t status;

   // model contents, front is the head word
   word_t   model_q[$];
   // expectations waiting for their compare cycle
   status_t exp_stat_q[$];
   word_t   exp_head_q[$];
   int      exp_due_q[$];
   int      cycle_cnt = 0;
   word_t   next_word = 16'h1000;
   string   cur_test = "none";
   int      test_errs = 0;
   int      tests_passed = 0;
   int      tests_failed = 0;

   burst_fifo i_dut (
      .clk        (clk),
      .reset_i    (reset_i),
      .push_stb_i (push_stb),
      .push_i     (push),
      .pop_stb_i  (pop_stb),
      .head_o     (head),
      .status_o   (status)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period_c / 2) clk = ~clk;
   end

   // admission rules against the level before the edge
   function automatic step_t predict_step(input logic stb, input int cnt, input logic pop,
                                          input int level);
      step_t s;
      int    room;
      logic  req;
      s = '0;
      s.pop_ok = pop && (level > 0);
      // a same-cycle pop frees one more slot
      room = fifo_slots_c - level + (s.pop_ok ? 1 : 0);
      req = stb && (cnt != 0);
      if (req && (cnt <= max_push_c) && (cnt <= room))
      begin
         s.acc = 2'(cnt);
      end
      s.drop = req && (s.acc == '0);
      s.perr = pop && !s.pop_ok;
      return s;
   endfunction

   task automatic check_word(input word_t exp, input word_t act);
      if (act !== exp)
      begin
         $display("Error %s head expected %h actual %h", cur_test, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_status(input status_t exp, input status_t act);
      if (act !== exp)
      begin
         $display("Error %s status expected %h actual %h", cur_test, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_level(input cnt_t exp, input cnt_t act);
      if (act !== exp)
      begin
         $display("Error %s level expected %0d actual %0d", cur_test, exp, act);
         test_errs++;
      end
   endtask

   // one cycle of stimulus, model updated in the same step
   task automatic drive_cycle(input logic stb, input logic [push_width_c-1:0] cnt,
                              input logic pop);
      step_t   s;
      status_t st;
      word_t   w0;
      word_t   w1;
      @(posedge clk);
      #drive_dly_c;
      w0 = next_word;
      w1 = next_word + 16'd1;
      next_word = next_word + 16'd2;
      push_stb = stb;
      push.count = cnt;
      push.word0 = w0;
      push.word1 = w1;
      pop_stb = pop;
      s = predict_step(stb, int'(cnt), pop, model_q.size());
      // pop leaves first, then the accepted words join the tail
      if (s.pop_ok)
      begin
         void'(model_q.pop_front());
      end
      if (s.acc != '0)
      begin
         model_q.push_back(w0);
      end
      if (s.acc == 2'd2)
      begin
         model_q.push_back(w1);
      end
      st.empty = (model_q.size() == 0);
      st.level = cnt_t'(model_q.size());
      st.push_drop = s.drop;
      st.pop_err = s.perr;
      exp_stat_q.push_back(st);
      exp_head_q.push_back((model_q.size() != 0) ? model_q[0] : '0);
      // sampled at the coming edge, visible right after it
      exp_due_q.push_back(cycle_cnt + 1);
   endtask

   task automatic drain_model();
      while (model_q.size() != 0)
      begin
         drive_cycle(1'b0, 2'd0, 1'b1);
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_errs = 0;
   endtask

   // idle one cycle, then let the compare process catch up
   task automatic end_test();
      drive_cycle(1'b0, 2'd0, 1'b0);
      while (exp_due_q.size() != 0)
      begin
         @(negedge clk);
      end
      if (test_errs == 0)
      begin
         tests_passed++;
         $display("test %s passed", cur_test);
      end
      else
      begin
         tests_failed++;
         $display("test %s failed with %0d errors", cur_test, test_errs);
      end
   endtask

   task automatic run_random();
      logic                    stb;
      logic [push_width_c-1:0] cnt;
      logic                    pop;
      repeat (rand_cycles_c)
      begin
         stb = 1'($urandom % 2);
         cnt = 2'($urandom % 3);
         pop = 1'($urandom % 2);
         drive_cycle(stb, cnt, pop);
      end
      drain_model();
   endtask

   // compare a quarter period after each edge, outputs settled by then
   initial
   begin
      status_t est;
      word_t   ehd;
      forever
      begin
         @(posedge clk);
         cycle_cnt++;
         #(clk_period_c / 4);
         while ((exp_due_q.size() != 0) && (exp_due_q[0] <= cycle_cnt))
         begin
            void'(exp_due_q.pop_front());
            est = exp_stat_q.pop_front();
            ehd = exp_head_q.pop_front();
            check_status(est, status);
            check_level(est.level, status.level);
            // head only means something while not empty
            if (!est.empty)
            begin
               check_word(ehd, head);
            end
         end
      end
   end

   initial
   begin
      #(limit_cycles_c * clk_period_c);
      $display("watchdog expired after %0d cycles, the tests did not finish", limit_cycles_c);
      $display("Simulation FAILED");
      $finish;
   end

   initial
   begin
      status_t rst_st;
      void'($urandom(seed_c));
      reset_i = 1'b1;
      push_stb = 1'b0;
      push = '0;
      pop_stb = 1'b0;
      repeat (reset_cycles_c) @(posedge clk);
      #drive_dly_c;
      reset_i = 1'b0;

      start_test("reset_state");
      rst_st = '{empty: 1'b1, level: '0, push_drop: 1'b0, pop_err: 1'b0};
      check_status(rst_st, status);
      check_level('0, status.level);
      end_test();

      // four in, four out twice, so the pointers pass slot 5
      start_test("single_push_pop");
      repeat (2)
      begin
         repeat (4) drive_cycle(1'b1, 2'd1, 1'b0);
         repeat (4) drive_cycle(1'b0, 2'd0, 1'b1);
      end
      end_test();

      // odd write pointer first so word1 lands in slot 0 on a wrap
      start_test("pair_push_pop");
      drive_cycle(1'b1, 2'd1, 1'b0);
      repeat (6)
      begin
         drive_cycle(1'b1, 2'd2, 1'b1);
         drive_cycle(1'b0, 2'd0, 1'b1);
      end
      drain_model();
      end_test();

      start_test("overflow");
      repeat (3) drive_cycle(1'b1, 2'd2, 1'b0);
      drive_cycle(1'b1, 2'd1, 1'b0);
      // pop frees only one slot, pair is still dropped
      drive_cycle(1'b1, 2'd2, 1'b1);
      drive_cycle(1'b1, 2'd1, 1'b0);
      // full, fits only through the same-cycle pop
      drive_cycle(1'b1, 2'd1, 1'b1);
      drive_cycle(1'b1, 2'd2, 1'b0);
      drain_model();
      end_test();

      start_test("underflow");
      repeat (2) drive_cycle(1'b0, 2'd0, 1'b1);
      drive_cycle(1'b1, 2'd1, 1'b1);
      drain_model();
      end_test();

      start_test("random_mix");
      run_random();
      end_test();

      $display("tests passed %0d failed %0d, assertion failures %0d",
               tests_passed, tests_failed, i_dut.i_ctrl.i_props.fail_cnt);
      if ((tests_failed == 0) && (i_dut.i_ctrl.i_props.fail_cnt == 0))
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
rtl/burst_fifo_pkg.sv
rtl/circ_ptr.sv
rtl/burst_fifo_ctrl.sv
rtl/burst_fifo_store.sv
rtl/burst_fifo.sv
dv/burst_fifo_props.sv
dv/burst_fifo_tb.sv

//--- Bender.yml
package:
  name: burst_fifo

sources:
  - rtl/burst_fifo_pkg.sv
  - rtl/circ_ptr.sv
  - rtl/burst_fifo_ctrl.sv
  - rtl/burst_fifo_store.sv
  - rtl/burst_fifo.sv
  - target: test
    files:
      - dv/burst_fifo_props.sv
      - dv/burst_fifo_tb.sv
